// File: hdl/gat_sizes_pkg.sv
// Matrix sizes, data widths and memory depths of the weight staging slice

package gat_sizes_pkg;

  // ==================================================================
  // Matrix and vector sizes
  // ==================================================================
  localparam int data_width      = 8;
  localparam int num_feature_in  = 8;
  localparam int num_feature_out = 4;

  // Attention vector holds a self half and a neighbour half
  localparam int a_depth = 2 * num_feature_out;
  localparam int half_a  = a_depth / 2;

  // ==================================================================
  // Source image layout
  // ==================================================================
  // W words first in row-major order, then the a words
  localparam int w_words     = num_feature_in * num_feature_out;
  localparam int image_depth = w_words + a_depth;

  // Index and address widths
  localparam int row_w        = $clog2(num_feature_in);
  localparam int col_w        = $clog2(num_feature_out);
  localparam int image_addr_w = $clog2(image_depth);
  localparam int a_idx_w      = $clog2(a_depth + 1);

  // ==================================================================
  // Result widths
  // ==================================================================
  // Full product plus growth for num_feature_in terms, plus a guard bit
  localparam int wh_w    = 2 * data_width + $clog2(num_feature_in) + 1;
  localparam int score_w = 32;

endpackage

// File: hdl/gat_types_pkg.sv
// Vector typedefs, packed structs and state enums of the weight staging slice

package gat_types_pkg;

  import gat_sizes_pkg::*;

  // ==================================================================
  // Scalar vectors
  // ==================================================================
  // Weights, attention coefficients and features share one format
  typedef logic signed [data_width-1:0] weight_t;

  typedef logic [row_w-1:0]        row_idx_t;
  typedef logic [col_w-1:0]        col_idx_t;
  typedef logic [image_addr_w-1:0] image_addr_t;
  typedef logic [a_idx_w-1:0]      a_idx_t;

  typedef logic signed [wh_w-1:0]    wh_t;
  typedef logic signed [score_w-1:0] score_t;

  // ==================================================================
  // Grouped signals
  // ==================================================================
  // Host write into the source memory
  typedef struct packed {
    image_addr_t addr;
    weight_t     data;
  } image_wr_t;

  // One element of a dense feature vector
  typedef struct packed {
    weight_t  value;
    row_idx_t row;
    logic     last;
  } feat_beat_t;

  // Projected features, one entry per output column
  typedef struct packed {
    wh_t [num_feature_out-1:0] col;
  } wh_vec_t;

  typedef struct packed {
    score_t self_score;
    score_t neigh_score;
  } attn_score_t;

  typedef weight_t [a_depth-1:0] attn_vec_t;

  // FSM encodings
  typedef enum logic [1:0] {load_idle, load_weights, load_attn, load_done} load_state_t;
  typedef enum logic [1:0] {proj_idle, proj_accum, proj_score} proj_state_t;

endpackage

// File: hdl/weight_image_ram.sv
// Source memory for the packed W and a image: host write port, one registered read

`timescale 1ns/1ps

module weight_image_ram (
  input  logic                       clk,
  input  logic                       wr_en,
  input  gat_types_pkg::image_wr_t   wr,
  input  gat_types_pkg::image_addr_t rd_addr,
  output gat_types_pkg::weight_t     rd_data
);

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  // W words at 0..w_words-1, a words above them
  weight_t mem [image_depth];
  weight_t rd_data_q;

  // ==================================================================
  // Host write port
  // ==================================================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // ==================================================================
  // Read port, one cycle latency
  // ==================================================================
  always_ff @(posedge clk) begin
    rd_data_q <= mem[rd_addr];
  end

  assign rd_data = rd_data_q;

endmodule

// File: hdl/column_weight_ram.sv
// Single W column memory: one write port and two independent registered read ports

`timescale 1ns/1ps

module column_weight_ram (
  input  logic                    clk,
  input  logic                    wr_en,
  input  gat_types_pkg::row_idx_t wr_row,
  input  gat_types_pkg::weight_t  wr_data,
  input  gat_types_pkg::row_idx_t rd_row_b,
  output gat_types_pkg::weight_t  rd_data_b,
  input  gat_types_pkg::row_idx_t rd_row_c,
  output gat_types_pkg::weight_t  rd_data_c
);

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  // One entry per W row
  weight_t mem [num_feature_in];
  weight_t rd_data_b_q;
  weight_t rd_data_c_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // Port B feeds the projector, port C the host readback
  always_ff @(posedge clk) begin
    rd_data_b_q <= mem[rd_row_b];
    rd_data_c_q <= mem[rd_row_c];
  end

  assign rd_data_b = rd_data_b_q;
  assign rd_data_c = rd_data_c_q;

endmodule

// File: hdl/weight_loader.sv
// Weight loader FSM: streams the image, scatters W by column, captures a, raises loaded

`timescale 1ns/1ps

module weight_loader (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      load_en,
  output gat_types_pkg::image_addr_t                image_rd_addr,
  input  gat_types_pkg::weight_t                    image_rd_data,
  output logic [gat_sizes_pkg::num_feature_out-1:0] col_wr_en,
  output gat_types_pkg::row_idx_t                   col_wr_row,
  output gat_types_pkg::weight_t                    col_wr_data,
  output gat_types_pkg::attn_vec_t                  attn,
  output logic                                      loaded
);

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  load_state_t state;

  // Read side
  image_addr_t rd_addr_q;
  logic        issue_done;
  logic        issue;

  // Write side, one cycle behind the read side
  logic        wr_vld_q;
  image_addr_t wr_addr_q;
  row_idx_t    wr_row;
  col_idx_t    wr_col;
  image_addr_t attn_offset;
  a_idx_t      attn_idx;

  attn_vec_t   attn_q;
  logic        loaded_q;

  // ==================================================================
  // Address issue
  // ==================================================================
  // Pausing load_en simply stops the walk
  assign issue = load_en && !issue_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q  <= '0;
      issue_done <= 1'b0;
      wr_vld_q   <= 1'b0;
      wr_addr_q  <= '0;
    end else begin
      wr_vld_q <= issue;
      if (issue) begin
        wr_addr_q <= rd_addr_q;
        if (rd_addr_q == image_addr_t'(image_depth - 1)) begin
          issue_done <= 1'b1;
        end else begin
          rd_addr_q <= rd_addr_q + 1'b1;
        end
      end
    end
  end

  assign image_rd_addr = rd_addr_q;

  // ==================================================================
  // Word decode
  // ==================================================================
  // Row-major W: low bits pick the column, the rest the row
  assign wr_col      = wr_addr_q[col_w-1:0];
  assign wr_row      = wr_addr_q[col_w +: row_w];
  assign attn_offset = wr_addr_q - image_addr_t'(w_words);
  assign attn_idx    = attn_offset[a_idx_w-1:0];

  always_comb begin
    col_wr_en = '0;
    if (wr_vld_q && state == load_weights) begin
      col_wr_en[wr_col] = 1'b1;
    end
  end

  assign col_wr_row  = wr_row;
  assign col_wr_data = image_rd_data;

  always_ff @(posedge clk) begin
    if (wr_vld_q && state == load_attn) begin
      attn_q[attn_idx] <= image_rd_data;
    end
  end

  // ==================================================================
  // Load FSM, follows the write side
  // ==================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= load_idle;
    end else begin
      case (state)
        load_idle: begin
          if (issue) begin
            state <= load_weights;
          end
        end
        load_weights: begin
          if (wr_vld_q && wr_addr_q == image_addr_t'(w_words - 1)) begin
            state <= load_attn;
          end
        end
        load_attn: begin
          if (wr_vld_q && wr_addr_q == image_addr_t'(image_depth - 1)) begin
            state <= load_done;
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  // Sticky, one register after load_done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      loaded_q <= 1'b0;
    end else if (state == load_done) begin
      loaded_q <= 1'b1;
    end
  end

  assign attn   = attn_q;
  assign loaded = loaded_q;

endmodule

// File: hdl/wh_projector.sv
// WH projector: parallel multiply-accumulate over W columns and attention half-scores

`timescale 1ns/1ps

module wh_projector (
  input  logic                                                        clk,
  input  logic                                                        rst_n,
  input  logic                                                        loaded,
  input  logic                                                        feat_vld,
  input  gat_types_pkg::feat_beat_t                                   feat,
  input  gat_types_pkg::attn_vec_t                                    attn,
  output gat_types_pkg::row_idx_t                                     rd_row,
  input  gat_types_pkg::weight_t [gat_sizes_pkg::num_feature_out-1:0] col_data,
  output logic                                                        wh_vld,
  output gat_types_pkg::wh_vec_t                                      wh,
  output logic                                                        score_vld,
  output gat_types_pkg::attn_score_t                                  score
);

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  proj_state_t state;

  logic                      accept;
  logic                      beat_vld_q;
  feat_beat_t                beat_q;
  wh_t [num_feature_out-1:0] acc_q;
  wh_t [num_feature_out-1:0] acc_next;
  wh_vec_t                   wh_q;
  attn_score_t               score_next;
  attn_score_t               score_q;
  logic                      score_vld_q;

  // ==================================================================
  // Beat intake
  // ==================================================================
  // Nothing is taken before the weights are in place
  assign accept = feat_vld && loaded;
  assign rd_row = feat.row;

  // Hold the beat one cycle, until its weights come back
  always_ff @(posedge clk) begin
    if (accept) begin
      beat_q <= feat;
    end
  end

  // ==================================================================
  // Multiply-accumulate
  // ==================================================================
  always_comb begin
    for (int c = 0; c < num_feature_out; c++) begin
      acc_next[c] = acc_q[c] + wh_t'(col_data[c]) * wh_t'(beat_q.value);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_vld_q  <= 1'b0;
      acc_q       <= '0;
      state       <= proj_idle;
      score_vld_q <= 1'b0;
    end else begin
      beat_vld_q  <= accept;
      score_vld_q <= (state == proj_score);
      if (beat_vld_q) begin
        acc_q <= beat_q.last ? '0 : acc_next;
      end
      if (beat_vld_q && beat_q.last) begin
        state <= proj_score;
      end else if (accept) begin
        state <= proj_accum;
      end else if (state == proj_score) begin
        state <= proj_idle;
      end
    end
  end

  // Final sum of the vector
  always_ff @(posedge clk) begin
    if (beat_vld_q && beat_q.last) begin
      wh_q.col <= acc_next;
    end
  end

  // ==================================================================
  // Attention half-scores
  // ==================================================================
  // First half of a against WH for self, second half for neighbour
  always_comb begin
    score_next = '0;
    for (int i = 0; i < half_a; i++) begin
      score_next.self_score = score_next.self_score
                            + score_t'(attn[i]) * score_t'(wh_q.col[i]);
      score_next.neigh_score = score_next.neigh_score
                             + score_t'(attn[half_a + i]) * score_t'(wh_q.col[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (state == proj_score) begin
      score_q <= score_next;
    end
  end

  assign wh_vld    = (state == proj_score);
  assign wh        = wh_q;
  assign score_vld = score_vld_q;
  assign score     = score_q;

endmodule

// File: hdl/gat_weight_top.sv
// Top level: source memory, weight loader, column memories, projector and host readback

`timescale 1ns/1ps

module gat_weight_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        image_wr_en,
  input  gat_types_pkg::image_wr_t    image_wr,
  input  logic                        load_en,
  output logic                        loaded,
  input  logic                        feat_vld,
  input  gat_types_pkg::feat_beat_t   feat,
  output logic                        wh_vld,
  output gat_types_pkg::wh_vec_t      wh,
  output logic                        score_vld,
  output gat_types_pkg::attn_score_t  score,
  input  gat_types_pkg::row_idx_t     rd_row,
  input  gat_types_pkg::col_idx_t     rd_col,
  output gat_types_pkg::weight_t      rd_data
);

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  image_addr_t                   image_rd_addr;
  weight_t                       image_rd_data;
  logic [num_feature_out-1:0]    col_wr_en;
  row_idx_t                      col_wr_row;
  weight_t                       col_wr_data;
  attn_vec_t                     attn;
  row_idx_t                      proj_rd_row;
  weight_t [num_feature_out-1:0] col_data_b;
  weight_t [num_feature_out-1:0] col_data_c;
  col_idx_t                      rd_col_q;

  weight_image_ram i_weight_image_ram (
    .clk     (clk),
    .wr_en   (image_wr_en),
    .wr      (image_wr),
    .rd_addr (image_rd_addr),
    .rd_data (image_rd_data)
  );

  weight_loader i_weight_loader (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_en       (load_en),
    .image_rd_addr (image_rd_addr),
    .image_rd_data (image_rd_data),
    .col_wr_en     (col_wr_en),
    .col_wr_row    (col_wr_row),
    .col_wr_data   (col_wr_data),
    .attn          (attn),
    .loaded        (loaded)
  );

  // ==================================================================
  // One memory per W column
  // ==================================================================
  for (genvar c = 0; c < num_feature_out; c++) begin : g_col
    column_weight_ram i_column_weight_ram (
      .clk       (clk),
      .wr_en     (col_wr_en[c]),
      .wr_row    (col_wr_row),
      .wr_data   (col_wr_data),
      .rd_row_b  (proj_rd_row),
      .rd_data_b (col_data_b[c]),
      .rd_row_c  (rd_row),
      .rd_data_c (col_data_c[c])
    );
  end

  wh_projector i_wh_projector (
    .clk       (clk),
    .rst_n     (rst_n),
    .loaded    (loaded),
    .feat_vld  (feat_vld),
    .feat      (feat),
    .attn      (attn),
    .rd_row    (proj_rd_row),
    .col_data  (col_data_b),
    .wh_vld    (wh_vld),
    .wh        (wh),
    .score_vld (score_vld),
    .score     (score)
  );

  // Column select follows the port C read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_col_q <= '0;
    end else begin
      rd_col_q <= rd_col;
    end
  end

  assign rd_data = col_data_c[rd_col_q];

endmodule

// File: bench/gat_weight_assert.sv
// Bound concurrent assertions on loaded, wh_vld and score_vld timing

`timescale 1ns/1ps

module gat_weight_assert (
  input logic clk,
  input logic rst_n,
  input logic loaded,
  input logic wh_vld,
  input logic score_vld
);

  // Results only exist once the weights are in place
  result_needs_loaded: assert property (@(posedge clk) disable iff (!rst_n)
    (wh_vld || score_vld) |-> loaded)
    else $error("wh_vld or score_vld high while loaded is low");

  // Scores come one cycle after WH
  score_after_wh: assert property (@(posedge clk) disable iff (!rst_n)
    wh_vld |=> score_vld)
    else $error("score_vld missing one cycle after wh_vld");

  score_has_wh: assert property (@(posedge clk) disable iff (!rst_n)
    score_vld |-> $past(wh_vld))
    else $error("score_vld without wh_vld one cycle before");

  // Sticky until the next reset
  loaded_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    !$fell(loaded))
    else $error("loaded fell outside reset");

endmodule

bind gat_weight_top gat_weight_assert i_gat_weight_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .loaded    (loaded),
  .wh_vld    (wh_vld),
  .score_vld (score_vld)
);

// File: bench/tb_gat_weight.sv
// Testbench for the weight staging slice: clock, reset, stimulus, reference model, checks

`timescale 1ns/1ps

module tb_gat_weight;

  import gat_sizes_pkg::*;
  import gat_types_pkg::*;

  localparam int timeout_cycles = 600;
  localparam int load_cycles    = 42;

  logic        clk;
  logic        rst_n;
  logic        image_wr_en;
  image_wr_t   image_wr;
  logic        load_en;
  logic        loaded;
  logic        feat_vld;
  feat_beat_t  feat;
  logic        wh_vld;
  wh_vec_t     wh;
  logic        score_vld;
  attn_score_t score;
  row_idx_t    rd_row;
  col_idx_t    rd_col;
  weight_t     rd_data;

  int seed      = 32'h6463_669f;
  int cycle_cnt = 0;
  int err_cnt   = 0;

  // Host copy of the image, W first and a behind it
  weight_t image [image_depth];

  // Expected results and the cycle each one is due in
  wh_vec_t     exp_wh_q [$];
  attn_score_t exp_score_q [$];
  int          wh_due_q [$];
  int          score_due_q [$];

  gat_weight_top i_gat_weight_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .image_wr_en (image_wr_en),
    .image_wr    (image_wr),
    .load_en     (load_en),
    .loaded      (loaded),
    .feat_vld    (feat_vld),
    .feat        (feat),
    .wh_vld      (wh_vld),
    .wh          (wh),
    .score_vld   (score_vld),
    .score       (score),
    .rd_row      (rd_row),
    .rd_col      (rd_col),
    .rd_data     (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================================
  // Error reporting
  // ==================================================================
  task automatic value_error(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    err_cnt++;
    $display("Fail %s expected %h got %h", name, expected, actual);
    $display("Testbench failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  endtask

  // ==================================================================
  // Reference model
  // ==================================================================
  // WH column c is the feature vector against W column c
  function automatic wh_vec_t ref_wh(input weight_t fv [num_feature_in]);
    wh_vec_t res;
    int      sum;
    for (int c = 0; c < num_feature_out; c++) begin
      sum = 0;
      for (int r = 0; r < num_feature_in; r++) begin
        sum += int'(fv[r]) * int'(image[r * num_feature_out + c]);
      end
      res.col[c] = wh_t'(sum);
    end
    return res;
  endfunction

  // Self half uses a[0..3], neighbour half a[4..7]
  function automatic attn_score_t ref_scores(input wh_vec_t w);
    attn_score_t res;
    longint      self_sum;
    longint      neigh_sum;
    self_sum  = 0;
    neigh_sum = 0;
    for (int i = 0; i < half_a; i++) begin
      self_sum  += longint'(image[w_words + i]) * longint'($signed(w.col[i]));
      neigh_sum += longint'(image[w_words + half_a + i]) * longint'($signed(w.col[i]));
    end
    res.self_score  = score_t'(self_sum);
    res.neigh_score = score_t'(neigh_sum);
    return res;
  endfunction

  // ==================================================================
  // Stimulus tasks
  // ==================================================================
  task automatic apply_reset();
    @(negedge clk);
    rst_n    = 1'b0;
    load_en  = 1'b0;
    feat_vld = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic write_image();
    for (int a = 0; a < image_depth; a++) begin
      @(negedge clk);
      image[a]      = weight_t'($random(seed));
      image_wr_en   = 1'b1;
      image_wr.addr = image_addr_t'(a);
      image_wr.data = image[a];
    end
    @(negedge clk);
    image_wr_en = 1'b0;
  endtask

  task automatic wait_for_loaded(output int cycles);
    cycles = 0;
    while (!loaded) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  // Port C readback, next address driven while the previous word is checked
  task automatic check_readback();
    for (int a = 0; a <= w_words; a++) begin
      @(negedge clk);
      if (a > 0) begin
        assert (rd_data === image[a - 1])
          else value_error($sformatf("rd_data row %0d col %0d", (a - 1) / num_feature_out,
                                     (a - 1) % num_feature_out),
                           32'(image[a - 1]), 32'(rd_data));
      end
      if (a < w_words) begin
        rd_row = row_idx_t'(a / num_feature_out);
        rd_col = col_idx_t'(a % num_feature_out);
      end
    end
  endtask

  // Pulses sent before loaded rises, none of them may produce a result
  task automatic send_ignored_beats(input int count);
    for (int i = 0; i < count; i++) begin
      @(negedge clk);
      feat_vld   = 1'b1;
      feat.value = weight_t'($random(seed));
      feat.row   = row_idx_t'(i);
      feat.last  = 1'b1;
      @(negedge clk);
      feat_vld = 1'b0;
    end
  endtask

  task automatic send_vector();
    weight_t fv [num_feature_in];
    wh_vec_t exp_wh;
    int      gap;
    for (int r = 0; r < num_feature_in; r++) begin
      fv[r] = weight_t'($random(seed));
    end
    exp_wh = ref_wh(fv);
    for (int r = 0; r < num_feature_in; r++) begin
      @(negedge clk);
      feat_vld   = 1'b1;
      feat.value = fv[r];
      feat.row   = row_idx_t'(r);
      feat.last  = (r == num_feature_in - 1);
      if (r == num_feature_in - 1) begin
        exp_wh_q.push_back(exp_wh);
        exp_score_q.push_back(ref_scores(exp_wh));
        wh_due_q.push_back(cycle_cnt + 2);
        score_due_q.push_back(cycle_cnt + 3);
      end else begin
        gap = int'($unsigned($random(seed)) % 3);
        repeat (gap) begin
          @(negedge clk);
          feat_vld = 1'b0;
        end
      end
    end
    @(negedge clk);
    feat_vld = 1'b0;
    while (exp_score_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // ==================================================================
  // Result comparison
  // ==================================================================
  always @(negedge clk) begin : compare_results
    wh_vec_t     exp_wh;
    attn_score_t exp_score;
    int          due;
    if (rst_n && wh_vld) begin
      assert (exp_wh_q.size() != 0)
        else abort_run("wh_vld pulsed without a complete accepted feature vector");
      exp_wh = exp_wh_q.pop_front();
      due    = wh_due_q.pop_front();
      assert (cycle_cnt == due)
        else abort_run($sformatf("wh_vld came in cycle %0d instead of %0d", cycle_cnt, due));
      for (int c = 0; c < num_feature_out; c++) begin
        assert (wh.col[c] === exp_wh.col[c])
          else value_error($sformatf("wh.col[%0d]", c), 32'(exp_wh.col[c]), 32'(wh.col[c]));
      end
    end
    if (rst_n && score_vld) begin
      assert (exp_score_q.size() != 0)
        else abort_run("score_vld pulsed without a pending score");
      exp_score = exp_score_q.pop_front();
      due       = score_due_q.pop_front();
      assert (cycle_cnt == due)
        else abort_run($sformatf("score_vld came in cycle %0d instead of %0d", cycle_cnt, due));
      assert (score.self_score === exp_score.self_score)
        else value_error("score.self_score", exp_score.self_score, score.self_score);
      assert (score.neigh_score === exp_score.neigh_score)
        else value_error("score.neigh_score", exp_score.neigh_score, score.neigh_score);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < timeout_cycles)
      else abort_run($sformatf("Run did not finish within %0d cycles", timeout_cycles));
  end

  // ==================================================================
  // Test sequence
  // ==================================================================
  initial begin
    int load_wait;
    rst_n       = 1'b0;
    image_wr_en = 1'b0;
    image_wr    = '0;
    load_en     = 1'b0;
    feat_vld    = 1'b0;
    feat        = '0;
    rd_row      = '0;
    rd_col      = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Uninterrupted load
    write_image();
    @(negedge clk);
    load_en = 1'b1;
    wait_for_loaded(load_wait);
    assert (load_wait == load_cycles)
      else abort_run($sformatf("loaded rose after %0d cycles instead of %0d",
                               load_wait, load_cycles));
    check_readback();
    repeat (3) send_vector();

    // Paused load with feature pulses before loaded
    apply_reset();
    write_image();
    send_ignored_beats(2);
    @(negedge clk);
    load_en = 1'b1;
    repeat (15) @(negedge clk);
    load_en = 1'b0;
    send_ignored_beats(3);
    load_en = 1'b1;
    wait_for_loaded(load_wait);
    check_readback();
    send_vector();

    if (err_cnt == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "checks failed");
    end
  end

endmodule

// File: project.f
hdl/gat_sizes_pkg.sv
hdl/gat_types_pkg.sv
hdl/weight_image_ram.sv
hdl/column_weight_ram.sv
hdl/weight_loader.sv
hdl/wh_projector.sv
hdl/gat_weight_top.sv
bench/gat_weight_assert.sv
bench/tb_gat_weight.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the weight staging testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gat_weight -f project.f -o sim_gat_weight

out=$(./obj_dir/sim_gat_weight 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
